// ==== la_mmu.f ====
la_mmu_pkg.sv
tlb_match_single.sv
core_addr_trans.sv
tlb_write_port.sv
la_mmu_top.sv
la_mmu_props.sv
tb_la_mmu.sv

// ==== tb_la_mmu.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_la_mmu
  import la_mmu_pkg::*;
();

  logic                 clk;
  logic                 reset_i;
  logic                 tlbwr_i;
  logic                 invtlb_all_i;
  logic [TLB_IDX_W-1:0] tlbwr_idx_i;
  tlb_entry_t           tlbwr_entry_i;
  csr_t                 csr_i;
  logic                 valid_i;
  logic                 stall_i;
  logic                 jmp_i;
  logic                 flush_i;
  logic [31:0]          vaddr_i;
  tlb_s_resp_t          if_trans_o;
  tlb_s_resp_t          mem_trans_o;
  tlb_entry_t           tlb_model [TLB_ENTRY_NUM];
  logic [31:0]          lcg_state = 32'h6924;
  int                   cycle_count = 0;
  int                   error_count = 0;

  // Both sides share one set of request signals
  la_mmu_top la_mmu_top_inst (
    .clk           (clk),
    .reset_i       (reset_i),
    .tlbwr_i       (tlbwr_i),
    .tlbwr_idx_i   (tlbwr_idx_i),
    .tlbwr_entry_i (tlbwr_entry_i),
    .invtlb_all_i  (invtlb_all_i),
    .csr_i         (csr_i),
    .if_valid_i    (valid_i),
    .if_vaddr_i    (vaddr_i),
    .if_stall_i    (stall_i),
    .if_jmp_i      (jmp_i),
    .if_flush_i    (flush_i),
    .mem_valid_i   (valid_i),
    .mem_vaddr_i   (vaddr_i),
    .mem_stall_i   (stall_i),
    .mem_jmp_i     (jmp_i),
    .mem_flush_i   (flush_i),
    .if_trans_o    (if_trans_o),
    .mem_trans_o   (mem_trans_o)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count == 2000) begin
      $display("Timeout: the tests did not finish within 2000 cycles");
      $display("TEST FAILED");
      $fatal(1, "Timeout");
    end
  end

  function automatic logic [31:0] next_rand();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // Reference model of the source selection
  function automatic tlb_s_resp_t expected_resp(input logic fetch, input logic [31:0] va);
    tlb_s_resp_t r;
    tlb_key_t    key;
    logic [31:0] win;
    logic        hit;
    logic        odd;
    r = '0;
    if (csr_i.crmd[CRMD_DA]) begin
      r.dmw   = 1'b1;
      r.found = 1'b1;
      r.ps    = PS_4K;
      r.value = '{ppn: va[31:12], v: 1'b1, d: 1'b1, plv: 2'b11,
                  mat: fetch ? csr_i.crmd[6:5] : csr_i.crmd[8:7]};
      return r;
    end
    for (int w = 0; w < 2; w++) begin
      win = (w == 0) ? csr_i.dmw0 : csr_i.dmw1;
      if (va[31:29] == win[31:29] && ((win[0] && csr_i.crmd[1:0] == 2'd0) ||
                                      (win[3] && csr_i.crmd[1:0] == 2'd3))) begin
        r.dmw   = 1'b1;
        r.found = 1'b1;
        r.ps    = PS_4K;
        r.value = '{ppn: {win[27:25], va[28:12]}, v: 1'b1, d: 1'b1, mat: win[5:4],
                    plv: win[3] ? 2'b11 : 2'b00};
        return r;
      end
    end
    for (int k = 0; k < TLB_ENTRY_NUM; k++) begin
      key = tlb_model[k].key;
      hit = (key.ps == PS_4M) ? key.vppn[18:10] == va[31:23] : key.vppn == va[31:13];
      odd = (key.ps == PS_4M) ? va[22] : va[12];
      if (key.e && hit && (key.g || key.asid == csr_i.asid[9:0])) begin
        r.found = 1'b1;
        r.index = TLB_IDX_W'(k);
        r.ps    = key.ps;
        r.value = tlb_model[k].value[odd];
        return r;
      end
    end
    return r;
  endfunction

  function automatic tlb_entry_t make_entry(input logic [18:0] vppn, input logic [5:0] ps,
                                            input logic g, input logic [9:0] asid);
    tlb_entry_t  ent;
    logic [31:0] r0;
    logic [31:0] r1;
    r0 = next_rand();
    r1 = next_rand();
    ent.key      = '{vppn: vppn, ps: ps, g: g, asid: asid, e: 1'b1};
    ent.value[0] = r0[25:0];
    ent.value[1] = r1[25:0];
    return ent;
  endfunction

  task automatic check_resp(input string name, input tlb_s_resp_t exp, input tlb_s_resp_t act);
    if (act !== exp) begin
      error_count++;
      $display("** Error %s: expected %h, actual %h", name, exp, act);
      $display("TEST FAILED");
      $fatal(1, "Result mismatch in %s", name);
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      error_count++;
      $display("** Error %s: expected %b, actual %b", name, exp, act);
      $display("TEST FAILED");
      $fatal(1, "Flag mismatch in %s", name);
    end
  endtask

  task automatic set_csr(input logic [31:0] crmd, input logic [31:0] asid,
                         input logic [31:0] dmw0, input logic [31:0] dmw1);
    @(posedge clk);
    csr_i <= '{crmd: crmd, asid: asid, dmw0: dmw0, dmw1: dmw1};
  endtask

  task automatic drive(input logic [31:0] va, input logic stall, input logic jmp,
                       input logic flush);
    @(posedge clk);
    vaddr_i <= va;
    stall_i <= stall;
    jmp_i   <= jmp;
    flush_i <= flush;
  endtask

  // Capture edge, then sample away from it
  task automatic settle();
    @(posedge clk);
    @(negedge clk);
  endtask

  task automatic translate(input string name, input logic [31:0] va);
    drive(va, 1'b0, 1'b0, 1'b0);
    settle();
    check_resp({name, " if"}, expected_resp(1'b1, va), if_trans_o);
    check_resp({name, " mem"}, expected_resp(1'b0, va), mem_trans_o);
  endtask

  task automatic write_tlb(input int idx, input tlb_entry_t ent, input logic inv);
    @(posedge clk);
    tlbwr_i       <= 1'b1;
    tlbwr_idx_i   <= TLB_IDX_W'(idx);
    tlbwr_entry_i <= ent;
    invtlb_all_i  <= inv;
    @(posedge clk);
    tlbwr_i      <= 1'b0;
    invtlb_all_i <= 1'b0;
    for (int k = 0; k < TLB_ENTRY_NUM; k++) begin
      if (inv) begin
        tlb_model[k].key.e = 1'b0;
      end
    end
    if (!inv) begin
      tlb_model[idx] = ent;
    end
  endtask

  task automatic test_reset_da();
    tlb_s_resp_t exp;
    logic [31:0] va;
    check_resp("reset if", '0, if_trans_o);
    check_resp("reset mem", '0, mem_trans_o);
    check_bit("reset found", 1'b0, if_trans_o.found);
    // DA with DATF 01 and DATM 10
    set_csr(32'h128, 32'h0, 32'h0, 32'h0);
    repeat (8) translate("da", next_rand());
    // Invalid request keeps found low
    va = next_rand();
    @(posedge clk);
    valid_i <= 1'b0;
    vaddr_i <= va;
    settle();
    exp = expected_resp(1'b1, va);
    exp.found = 1'b0;
    check_resp("invalid if", exp, if_trans_o);
    exp = expected_resp(1'b0, va);
    exp.found = 1'b0;
    check_resp("invalid mem", exp, mem_trans_o);
    @(posedge clk);
    valid_i <= 1'b1;
  endtask

  task automatic test_dmw();
    logic [31:0] va;
    va = next_rand();
    va[31:29] = 3'b101;
    set_csr(32'h10, 32'h5, 32'hA200_0011, 32'h0);
    translate("dmw0 plv0", va);
    check_bit("dmw0 plv0 dmw", 1'b1, if_trans_o.dmw);
    set_csr(32'h13, 32'h5, 32'hA200_0011, 32'h0);
    translate("dmw0 plv3", va);
    check_bit("dmw0 plv3 found", 1'b0, if_trans_o.found);
    set_csr(32'h10, 32'h5, 32'hA200_0011, 32'hA400_0029);
    translate("dmw both", va);
    check_bit("dmw0 wins", 1'b1, if_trans_o.value.ppn[19:17] == 3'b001);
    set_csr(32'h13, 32'h5, 32'hA200_0011, 32'hA400_0029);
    translate("dmw1 plv3", va);
  endtask

  task automatic test_tlb_4k();
    tlb_entry_t  ent;
    logic [31:0] r;
    r = next_rand();
    set_csr(32'h10, 32'h5, 32'h0, 32'h0);
    ent = make_entry({9'h011, r[9:0]}, PS_4K, 1'b0, 10'h5);
    write_tlb(3, ent, 1'b0);
    translate("4k even", {ent.key.vppn, 1'b0, r[31:20]});
    check_bit("4k even found", 1'b1, if_trans_o.found);
    translate("4k odd", {ent.key.vppn, 1'b1, r[31:20]});
    set_csr(32'h10, 32'h6, 32'h0, 32'h0);
    translate("4k wrong asid", {ent.key.vppn, r[12:0]});
    check_bit("4k wrong asid found", 1'b0, if_trans_o.found);
    ent = make_entry({9'h022, r[19:10]}, PS_4K, 1'b1, 10'h9);
    write_tlb(7, ent, 1'b0);
    translate("4k global", {ent.key.vppn, r[12:0]});
    check_bit("4k global found", 1'b1, if_trans_o.found);
  endtask

  task automatic test_tlb_4m();
    logic [31:0] r;
    write_tlb(10, make_entry({9'h033, 10'h0}, PS_4M, 1'b1, 10'h0), 1'b0);
    repeat (6) begin
      r = next_rand();
      translate("4m hit", {9'h033, r[22:0]});
    end
    translate("4m miss", {9'h034, r[22:0]});
    check_bit("4m miss found", 1'b0, if_trans_o.found);
  endtask

  task automatic test_stall();
    tlb_s_resp_t held_if;
    tlb_s_resp_t held_mem;
    logic [31:0] va_jmp;
    set_csr(32'h128, 32'h0, 32'h0, 32'h0);
    translate("stall start", next_rand());
    held_if  = if_trans_o;
    held_mem = mem_trans_o;
    drive(next_rand(), 1'b1, 1'b0, 1'b0);
    settle();
    check_resp("stall hold if", held_if, if_trans_o);
    check_resp("stall hold mem", held_mem, mem_trans_o);
    va_jmp = next_rand();
    drive(va_jmp, 1'b1, 1'b1, 1'b0);
    settle();
    check_resp("jmp if", expected_resp(1'b1, va_jmp), if_trans_o);
    check_resp("jmp mem", expected_resp(1'b0, va_jmp), mem_trans_o);
    held_if  = if_trans_o;
    held_mem = mem_trans_o;
    drive(next_rand(), 1'b1, 1'b0, 1'b0);
    // New DATF and DATM only show up after the flush
    set_csr(32'hC8, 32'h0, 32'h0, 32'h0);
    settle();
    check_resp("stall csr hold if", held_if, if_trans_o);
    check_resp("stall csr hold mem", held_mem, mem_trans_o);
    drive(next_rand(), 1'b1, 1'b0, 1'b1);
    settle();
    check_resp("flush if", expected_resp(1'b1, va_jmp), if_trans_o);
    check_resp("flush mem", expected_resp(1'b0, va_jmp), mem_trans_o);
    drive(32'h0, 1'b0, 1'b0, 1'b0);
  endtask

  task automatic test_inv_all();
    tlb_entry_t ent;
    set_csr(32'h10, 32'h5, 32'h0, 32'h0);
    translate("inv before", {9'h033, 23'h12345});
    check_bit("inv before found", 1'b1, if_trans_o.found);
    ent = make_entry({9'h044, 10'h0}, PS_4K, 1'b1, 10'h0);
    write_tlb(12, ent, 1'b1);
    translate("inv old", {9'h033, 23'h12345});
    check_bit("inv old found", 1'b0, if_trans_o.found);
    translate("inv new", {ent.key.vppn, 13'h0});
    check_bit("inv new found", 1'b0, mem_trans_o.found);
  endtask

  initial begin
    reset_i       = 1'b1;
    tlbwr_i       = 1'b0;
    invtlb_all_i  = 1'b0;
    tlbwr_idx_i   = '0;
    tlbwr_entry_i = '0;
    csr_i         = '0;
    valid_i       = 1'b1;
    stall_i       = 1'b0;
    jmp_i         = 1'b0;
    flush_i       = 1'b0;
    vaddr_i       = '0;
    for (int k = 0; k < TLB_ENTRY_NUM; k++) begin
      tlb_model[k] = '0;
    end
    repeat (8) @(posedge clk);
    reset_i <= 1'b0;
    @(negedge clk);
    test_reset_da();
    test_dmw();
    test_tlb_4k();
    test_tlb_4m();
    test_stall();
    test_inv_all();
    if (error_count == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== la_mmu_props.sv ====
`timescale 1ns/1ps
`default_nettype none

module la_mmu_props
  import la_mmu_pkg::*;
(
  input wire                     clk,
  input wire                     reset_i,
  input wire                     stall_i,
  input wire                     jmp_i,
  input wire                     flush_i,
  input wire [TLB_ENTRY_NUM-1:0] tlb_match,
  input wire tlb_s_resp_t        trans_result_o
);

  // Back-pressure keeps the registered result
  hold_on_stall: assert property (@(posedge clk) disable iff (reset_i)
    stall_i && !jmp_i && !flush_i |=> $stable(trans_result_o))
    else $error("Result changed during a stall");

  clear_after_reset: assert property (@(posedge clk)
    reset_i |=> !trans_result_o.found)
    else $error("found set right after reset");

  // Stored keys are unique
  single_match: assert property (@(posedge clk) disable iff (reset_i)
    $onehot0(tlb_match))
    else $error("More than one TLB entry matched");

endmodule

bind core_addr_trans la_mmu_props la_mmu_props_inst (
  .clk            (clk),
  .reset_i        (reset_i),
  .stall_i        (stall_i),
  .jmp_i          (jmp_i),
  .flush_i        (flush_i),
  .tlb_match      (tlb_match),
  .trans_result_o (trans_result_o)
);

`default_nettype wire

// ==== la_mmu_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module la_mmu_top
  import la_mmu_pkg::*;
(
  input  wire                  clk,
  input  wire                  reset_i,
  input  wire                  tlbwr_i,
  input  wire  [TLB_IDX_W-1:0] tlbwr_idx_i,
  input  wire  tlb_entry_t     tlbwr_entry_i,
  input  wire                  invtlb_all_i,
  input  wire  csr_t           csr_i,
  input  wire                  if_valid_i,
  input  wire  [31:0]          if_vaddr_i,
  input  wire                  if_stall_i,
  input  wire                  if_jmp_i,
  input  wire                  if_flush_i,
  input  wire                  mem_valid_i,
  input  wire  [31:0]          mem_vaddr_i,
  input  wire                  mem_stall_i,
  input  wire                  mem_jmp_i,
  input  wire                  mem_flush_i,
  output tlb_s_resp_t          if_trans_o,
  output tlb_s_resp_t          mem_trans_o
);

  tlb_update_req_t update_req;

  tlb_write_port tlb_write_port_inst (
    .clk           (clk),
    .reset_i       (reset_i),
    .tlbwr_i       (tlbwr_i),
    .tlbwr_idx_i   (tlbwr_idx_i),
    .tlbwr_entry_i (tlbwr_entry_i),
    .invtlb_all_i  (invtlb_all_i),
    .update_req_o  (update_req)
  );

  // Instruction side
  core_addr_trans #(.FETCH_ADDR(1'b1)) if_trans_inst (
    .clk              (clk),
    .reset_i          (reset_i),
    .valid_i          (if_valid_i),
    .vaddr_i          (if_vaddr_i),
    .stall_i          (if_stall_i),
    .jmp_i            (if_jmp_i),
    .flush_i          (if_flush_i),
    .csr_i            (csr_i),
    .tlb_update_req_i (update_req),
    .trans_result_o   (if_trans_o)
  );

  // Load/store side
  core_addr_trans #(.FETCH_ADDR(1'b0)) mem_trans_inst (
    .clk              (clk),
    .reset_i          (reset_i),
    .valid_i          (mem_valid_i),
    .vaddr_i          (mem_vaddr_i),
    .stall_i          (mem_stall_i),
    .jmp_i            (mem_jmp_i),
    .flush_i          (mem_flush_i),
    .csr_i            (csr_i),
    .tlb_update_req_i (update_req),
    .trans_result_o   (mem_trans_o)
  );

endmodule

`default_nettype wire

// ==== tlb_write_port.sv ====
`timescale 1ns/1ps
`default_nettype none

module tlb_write_port
  import la_mmu_pkg::*;
(
  input  wire                  clk,
  input  wire                  reset_i,
  input  wire                  tlbwr_i,
  input  wire  [TLB_IDX_W-1:0] tlbwr_idx_i,
  input  wire  tlb_entry_t     tlbwr_entry_i,
  input  wire                  invtlb_all_i,
  output tlb_update_req_t      update_req_o
);

  logic [TLB_ENTRY_NUM-1:0] we_onehot;

  // Invalidate wins over a write in the same cycle
  always_comb begin
    we_onehot = '0;
    if (tlbwr_i && !invtlb_all_i) begin
      we_onehot = TLB_ENTRY_NUM'(1) << tlbwr_idx_i;
    end
  end

  always_ff @(posedge clk) begin
    if (reset_i) begin
      update_req_o <= '0;
    end else begin
      update_req_o.tlb_we      <= we_onehot;
      update_req_o.tlb_inv_all <= invtlb_all_i;
      update_req_o.tlb_w_entry <= tlbwr_entry_i;
    end
  end

endmodule

`default_nettype wire

// ==== core_addr_trans.sv ====
`timescale 1ns/1ps
`default_nettype none

module core_addr_trans
  import la_mmu_pkg::*;
#(
  parameter bit FETCH_ADDR = 1'b0
) (
  input  wire                  clk,
  input  wire                  reset_i,
  input  wire                  valid_i,
  input  wire  [31:0]          vaddr_i,
  input  wire                  stall_i,
  input  wire                  jmp_i,
  input  wire                  flush_i,
  input  wire  csr_t           csr_i,
  input  wire  tlb_update_req_t tlb_update_req_i,
  output tlb_s_resp_t          trans_result_o
);

  function automatic logic dmw_hit(input logic [31:0] dmw, input logic [31:0] va,
                                   input logic [1:0] plv);
    return va[31:29] == dmw[DMW_VSEG_HI:DMW_VSEG_LO] &&
           ((dmw[DMW_PLV0] && plv == 2'd0) || (dmw[DMW_PLV3] && plv == 2'd3));
  endfunction

  function automatic tlb_s_resp_t dmw_resp(input logic [31:0] dmw, input logic [31:0] va);
    tlb_s_resp_t r;
    r           = '0;
    r.dmw       = 1'b1;
    r.found     = 1'b1;
    r.ps        = PS_4K;
    r.value.ppn = {dmw[DMW_PSEG_HI:DMW_PSEG_LO], va[28:12]};
    r.value.v   = 1'b1;
    r.value.d   = 1'b1;
    r.value.mat = dmw[DMW_MAT_HI:DMW_MAT_LO];
    r.value.plv = dmw[DMW_PLV3] ? 2'b11 : 2'b00;
    return r;
  endfunction

  logic [31:0]              vaddr;
  logic [31:0]              vaddr_q;
  logic [1:0]               plv;
  logic [TLB_ENTRY_NUM-1:0] tlb_match;
  tlb_value_t [1:0]         tlb_value_q [TLB_ENTRY_NUM];
  logic [TLB_ENTRY_NUM-1:0] is_4m_q;
  tlb_s_resp_t              tlb_result;
  tlb_s_resp_t              da_result;
  tlb_s_resp_t              next_result;

  // Keep the address of the stalled request
  always_ff @(posedge clk) begin
    if (!stall_i || jmp_i) begin
      vaddr_q <= vaddr_i;
    end
  end

  assign vaddr = (stall_i && !jmp_i) ? vaddr_q : vaddr_i;
  assign plv   = csr_i.crmd[CRMD_PLV_HI:CRMD_PLV_LO];

  for (genvar i = 0; i < TLB_ENTRY_NUM; i++) begin : g_entry
    tlb_match_single tlb_match_single_inst (
      .clk          (clk),
      .reset_i      (reset_i),
      .vppn_i       (vaddr[31:13]),
      .asid_i       (csr_i.asid[9:0]),
      .update_i     (tlb_update_req_i.tlb_we[i]),
      .inv_all_i    (tlb_update_req_i.tlb_inv_all),
      .update_key_i (tlb_update_req_i.tlb_w_entry.key),
      .match_o      (tlb_match[i])
    );
  end

  // Page pairs and size flag per entry
  always_ff @(posedge clk) begin
    for (int i = 0; i < TLB_ENTRY_NUM; i++) begin
      if (tlb_update_req_i.tlb_we[i]) begin
        tlb_value_q[i] <= tlb_update_req_i.tlb_w_entry.value;
        is_4m_q[i]     <= tlb_update_req_i.tlb_w_entry.key.ps == PS_4M;
      end
    end
  end

  // Match vector is one-hot, so OR in the hitting entry
  always_comb begin
    tlb_result = '0;
    for (int i = 0; i < TLB_ENTRY_NUM; i++) begin
      if (tlb_match[i]) begin
        tlb_result.found = 1'b1;
        tlb_result.index |= TLB_IDX_W'(i);
        tlb_result.ps    |= is_4m_q[i] ? PS_4M : PS_4K;
        tlb_result.value |= tlb_value_q[i][is_4m_q[i] ? vaddr[22] : vaddr[12]];
      end
    end
  end

  always_comb begin
    da_result           = '0;
    da_result.dmw       = 1'b1;
    da_result.found     = 1'b1;
    da_result.ps        = PS_4K;
    da_result.value.ppn = vaddr[31:12];
    da_result.value.v   = 1'b1;
    da_result.value.d   = 1'b1;
    da_result.value.plv = 2'b11;
    da_result.value.mat = FETCH_ADDR ? csr_i.crmd[CRMD_DATF_HI:CRMD_DATF_LO]
                                     : csr_i.crmd[CRMD_DATM_HI:CRMD_DATM_LO];
  end

  // DA, then DMW0, then DMW1, then TLB
  always_comb begin
    if (csr_i.crmd[CRMD_DA]) begin
      next_result = da_result;
    end else if (dmw_hit(csr_i.dmw0, vaddr, plv)) begin
      next_result = dmw_resp(csr_i.dmw0, vaddr);
    end else if (dmw_hit(csr_i.dmw1, vaddr, plv)) begin
      next_result = dmw_resp(csr_i.dmw1, vaddr);
    end else begin
      next_result = tlb_result;
    end
    if (!valid_i) begin
      next_result.found = 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (reset_i) begin
      trans_result_o <= '0;
    end else if (!stall_i || flush_i || jmp_i) begin
      trans_result_o <= next_result;
    end
  end

endmodule

`default_nettype wire

// ==== tlb_match_single.sv ====
`timescale 1ns/1ps
`default_nettype none

module tlb_match_single
  import la_mmu_pkg::*;
(
  input  wire         clk,
  input  wire         reset_i,
  input  wire  [18:0] vppn_i,
  input  wire  [9:0]  asid_i,
  input  wire         update_i,
  input  wire         inv_all_i,
  input  wire  tlb_key_t update_key_i,
  output logic        match_o
);

  logic [18:0] vppn_q;
  logic [9:0]  asid_q;
  logic        g_q;
  logic        is_4m_q;
  logic        e_q;

  always_ff @(posedge clk) begin
    if (update_i) begin
      vppn_q  <= update_key_i.vppn;
      asid_q  <= update_key_i.asid;
      g_q     <= update_key_i.g;
      is_4m_q <= update_key_i.ps == PS_4M;
    end
  end

  always_ff @(posedge clk) begin
    if (reset_i || inv_all_i) begin
      e_q <= 1'b0;
    end else if (update_i) begin
      e_q <= update_key_i.e;
    end
  end

  // 4M pages ignore the low ten vppn bits
  assign match_o = e_q &&
                   (g_q || asid_q == asid_i) &&
                   vppn_q[18:10] == vppn_i[18:10] &&
                   (is_4m_q || vppn_q[9:0] == vppn_i[9:0]);

endmodule

`default_nettype wire

// ==== la_mmu_pkg.sv ====
`default_nettype none

package la_mmu_pkg;

  // TLB geometry
  localparam int TLB_ENTRY_NUM = 16;
  localparam int TLB_IDX_W     = 4;

  // Legal page size codes
  localparam logic [5:0] PS_4K = 6'd12;
  localparam logic [5:0] PS_4M = 6'd22;

  // CRMD fields
  localparam int CRMD_PLV_HI  = 1;
  localparam int CRMD_PLV_LO  = 0;
  localparam int CRMD_DA      = 3;
  localparam int CRMD_PG      = 4;
  localparam int CRMD_DATF_HI = 6;
  localparam int CRMD_DATF_LO = 5;
  localparam int CRMD_DATM_HI = 8;
  localparam int CRMD_DATM_LO = 7;

  // DMW fields
  localparam int DMW_PLV0    = 0;
  localparam int DMW_PLV3    = 3;
  localparam int DMW_MAT_HI  = 5;
  localparam int DMW_MAT_LO  = 4;
  localparam int DMW_PSEG_HI = 27;
  localparam int DMW_PSEG_LO = 25;
  localparam int DMW_VSEG_HI = 31;
  localparam int DMW_VSEG_LO = 29;

  // CSR snapshot seen by both translators
  typedef struct packed {
    logic [31:0] crmd;
    logic [31:0] asid;
    logic [31:0] dmw0;
    logic [31:0] dmw1;
  } csr_t;

  // Search key of one entry
  typedef struct packed {
    logic [18:0] vppn;
    logic [5:0]  ps;
    logic        g;
    logic [9:0]  asid;
    logic        e;
  } tlb_key_t;

  // One page of the even/odd pair
  typedef struct packed {
    logic [19:0] ppn;
    logic        v;
    logic        d;
    logic [1:0]  mat;
    logic [1:0]  plv;
  } tlb_value_t;

  // Index 0 is the even page, index 1 the odd page
  typedef struct packed {
    tlb_key_t         key;
    tlb_value_t [1:0] value;
  } tlb_entry_t;

  typedef struct packed {
    logic [TLB_ENTRY_NUM-1:0] tlb_we;
    logic                     tlb_inv_all;
    tlb_entry_t               tlb_w_entry;
  } tlb_update_req_t;

  // Translation result, also used for DA and DMW hits
  typedef struct packed {
    logic                 dmw;
    logic                 found;
    logic [TLB_IDX_W-1:0] index;
    logic [5:0]           ps;
    tlb_value_t           value;
  } tlb_s_resp_t;

endpackage

`default_nettype wire
